/* build.f */
+incdir+common
+incdir+tests
common/muldiv_pkg.sv
muldiv/div_ctrl_fsm.sv
muldiv/div_step_counter.sv
muldiv/div_restoring_dp.sv
muldiv/muldiv_unit.sv
tests/muldiv_tb.sv

/* common/muldiv_pkg.sv */
// Shared types of the multiply/divide unit.
// Modules pull these in with a wildcard import in their header.
`include "muldiv_settings.svh"

package muldiv_pkg;

    // One data word, as seen on rs1, rs2 and the result.
    typedef logic [`MULDIV_DATA_WIDTH-1:0] word_t;

    // Full width product.
    typedef logic [2*`MULDIV_DATA_WIDTH-1:0] dword_t;

    // Divider iteration count, wide enough to hold MULDIV_DIV_STEPS itself.
    typedef logic [5:0] step_cnt_t;

    // Operation selected by funct3.
    typedef enum logic [2:0] {
        OP_MUL    = `FUNCT3_MUL,
        OP_MULH   = `FUNCT3_MULH,
        OP_MULHSU = `FUNCT3_MULHSU,
        OP_MULHU  = `FUNCT3_MULHU,
        OP_DIV    = `FUNCT3_DIV,
        OP_DIVU   = `FUNCT3_DIVU,
        OP_REM    = `FUNCT3_REM,
        OP_REMU   = `FUNCT3_REMU
    } muldiv_op_e;

    // Divider sequencing states.
    typedef enum logic [1:0] {
        DIV_IDLE = 2'b00,  // Waiting for a gated start.
        DIV_RUN  = 2'b01,  // One shift-subtract step per cycle.
        DIV_DONE = 2'b10   // Results final, busy drops next cycle.
    } div_state_e;

endpackage

/* common/muldiv_settings.svh */
// Build-time constants for the RV32M multiply/divide unit.
// Included by the package and by every module that sizes logic from them.
`ifndef MULDIV_SETTINGS_SVH
`define MULDIV_SETTINGS_SVH

`define MULDIV_DATA_WIDTH 32  // Operand and result width.
`define MULDIV_DIV_STEPS  32  // One divider iteration per quotient bit.

// RV32M funct3 operation codes.
`define FUNCT3_MUL    3'b000  // SxS, low word.
`define FUNCT3_MULH   3'b001  // SxS, high word.
`define FUNCT3_MULHSU 3'b010  // SxU, high word.
`define FUNCT3_MULHU  3'b011  // UxU, high word.
`define FUNCT3_DIV    3'b100  // Signed quotient.
`define FUNCT3_DIVU   3'b101  // Unsigned quotient.
`define FUNCT3_REM    3'b110  // Signed remainder.
`define FUNCT3_REMU   3'b111  // Unsigned remainder.

`endif

/* muldiv/div_ctrl_fsm.sv */
// Sequencer for one division: load, MULDIV_DIV_STEPS shift steps, then done.
// Start must only arrive while idle; the top gates it with busy.
module div_ctrl_fsm
    import muldiv_pkg::*;
(
    input  logic clk,
    input  logic rstLow,
    input  logic div_start_i,   // Gated start from the top.
    input  logic last_step_i,   // Counter is at its final step.
    output logic load_o,        // Capture operands into the datapath.
    output logic shift_en_o,    // One shift-subtract step.
    output logic step_clear_o,  // Reset the step counter.
    output logic step_en_o,     // Advance the step counter.
    output logic div_busy_o
);

    div_state_e state_q;
    div_state_e state_d;

    always_ff @(posedge clk or negedge rstLow) begin
        if (!rstLow) state_q <= DIV_IDLE;
        else         state_q <= state_d;
    end

    always_comb begin
        state_d      = state_q;
        load_o       = 1'b0;
        step_clear_o = 1'b0;
        shift_en_o   = 1'b0;
        step_en_o    = 1'b0;
        case (state_q)
            DIV_IDLE: begin
                if (div_start_i) begin
                    load_o       = 1'b1;  // Operands land on this edge.
                    step_clear_o = 1'b1;
                    state_d      = DIV_RUN;
                end
            end
            DIV_RUN: begin
                shift_en_o = 1'b1;
                step_en_o  = 1'b1;
                if (last_step_i) state_d = DIV_DONE;
            end
            DIV_DONE: state_d = DIV_IDLE;  // Registers are final here.
            default:  state_d = DIV_IDLE;
        endcase
    end

    assign div_busy_o = (state_q != DIV_IDLE);

    // The top's busy gating keeps starts out of RUN and DONE.
    a_start_only_idle: assert property (
        @(posedge clk) disable iff (!rstLow) div_start_i |-> state_q == DIV_IDLE
    );

endmodule

/* muldiv/div_restoring_dp.sv */
// Restoring shift-subtract divider datapath on unsigned operands.
// Results stay in place until the next load.
`include "muldiv_settings.svh"

module div_restoring_dp
    import muldiv_pkg::*;
(
    input  logic  clk,
    input  logic  rstLow,
    input  logic  load_i,       // Capture new operands.
    input  logic  shift_en_i,   // Perform one step.
    input  word_t dividend_i,
    input  word_t divisor_i,
    output word_t quotient_o,
    output word_t remainder_o
);

    localparam int W = `MULDIV_DATA_WIDTH;

    word_t       rem_q;    // Partial remainder.
    word_t       quo_q;    // Dividend shifts out, quotient bits shift in.
    word_t       div_q;    // Divisor held for the whole division.
    logic [W:0]  shifted;  // Remainder with next dividend bit appended.
    logic [W:0]  trial;    // Shifted remainder minus divisor.
    logic        fits;     // Divisor fits, subtraction is kept.

    assign shifted = {rem_q, quo_q[W-1]};
    assign trial   = shifted - {1'b0, div_q};
    assign fits    = ~trial[W];  // Non-negative trial result.

    always_ff @(posedge clk or negedge rstLow) begin
        if (!rstLow) begin
            rem_q <= '0;
            quo_q <= '0;
            div_q <= '0;
        end else if (load_i) begin
            rem_q <= '0;
            quo_q <= dividend_i;
            div_q <= divisor_i;
        end else if (shift_en_i) begin
            // Partial remainder stays below the divisor, so W bits suffice.
            rem_q <= fits ? trial[W-1:0] : shifted[W-1:0];
            quo_q <= {quo_q[W-2:0], fits};
        end
    end

    assign quotient_o  = quo_q;
    assign remainder_o = rem_q;

endmodule

/* muldiv/div_step_counter.sv */
// Iteration counter of the divider, flags the last shift step.
`include "muldiv_settings.svh"

module div_step_counter
    import muldiv_pkg::*;
(
    input  logic clk,
    input  logic rstLow,
    input  logic clear_i,     // Restart at zero on load.
    input  logic en_i,        // One step taken.
    output logic last_step_o  // Current step is the final one.
);

    step_cnt_t count_q;

    always_ff @(posedge clk or negedge rstLow) begin
        if (!rstLow) begin
            count_q <= '0;
        end else if (clear_i) begin
            count_q <= '0;
        end else if (en_i) begin
            count_q <= count_q + 1'b1;
        end
    end

    assign last_step_o = (count_q == step_cnt_t'(`MULDIV_DIV_STEPS - 1));

    // FSM leaves RUN on the last step, so the count stops at the step total.
    a_count_bound: assert property (
        @(posedge clk) disable iff (!rstLow) count_q <= step_cnt_t'(`MULDIV_DIV_STEPS)
    );

endmodule

/* muldiv/muldiv_unit.sv */
// RV32M execution unit with single-cycle multiply and multi-cycle restoring divide.
// The core holds the operands while start_i is high and polls busy_o.
`include "muldiv_settings.svh"

module muldiv_unit
    import muldiv_pkg::*;
(
    input  word_t      rs1_i,     // Multiplicand or dividend.
    input  word_t      rs2_i,     // Multiplier or divisor.
    input  muldiv_op_e funct3_i,  // Operation select.
    input  logic       start_i,   // Level strobe from the core.
    input  logic       clk,
    input  logic       rstLow,
    output word_t      c_o,       // Result.
    output logic       busy_o     // High while a division is running.
);

    localparam int MSB = `MULDIV_DATA_WIDTH - 1;

    // **************************************************
    // Operand sign handling
    // **************************************************
    logic  rs1_signed;  // rs1 read as two's complement.
    logic  rs2_signed;
    logic  sign_a;      // rs1 is a negative signed operand.
    logic  sign_b;
    word_t a;           // Magnitude fed to multiplier and divider.
    word_t b;

    assign rs1_signed = (funct3_i == OP_MUL) || (funct3_i == OP_MULH) ||
                        (funct3_i == OP_MULHSU) || (funct3_i == OP_DIV) ||
                        (funct3_i == OP_REM);
    assign rs2_signed = (funct3_i == OP_MUL) || (funct3_i == OP_MULH) ||
                        (funct3_i == OP_DIV) || (funct3_i == OP_REM);

    assign sign_a = rs1_signed & rs1_i[MSB];
    assign sign_b = rs2_signed & rs2_i[MSB];
    assign a      = sign_a ? (~rs1_i + 1'b1) : rs1_i;
    assign b      = sign_b ? (~rs2_i + 1'b1) : rs2_i;

    // **************************************************
    // Multiplier
    // **************************************************
    dword_t prod_u;  // Unsigned magnitude product.
    dword_t prod_s;  // Product with the sign put back.

    assign prod_u = dword_t'(a) * dword_t'(b);
    assign prod_s = (sign_a ^ sign_b) ? (~prod_u + 1'b1) : prod_u;

    // **************************************************
    // Division special cases and result reuse
    // **************************************************
    logic  is_div;
    logic  div0;       // Divisor is zero.
    logic  div_ovf;    // Most negative value over minus one in a signed op.
    logic  reuse_hit;  // Divider already holds this result.
    logic  div_start;  // Gated start to the FSM.
    logic  div_busy;
    word_t prev_a;     // Magnitudes of the last started division.
    word_t prev_b;

    assign is_div  = funct3_i[2];
    assign div0    = (rs2_i == '0);
    assign div_ovf = ~funct3_i[0] &
                     (rs1_i == {1'b1, {MSB{1'b0}}}) & (rs2_i == '1);

    // Magnitudes serve DIV and DIVU alike. The sign is applied afterwards.
    assign reuse_hit = (prev_a == a) && (prev_b == b);

    assign div_start = start_i & is_div & ~div0 & ~div_ovf & ~reuse_hit & ~div_busy;
    assign busy_o    = div_start | div_busy;  // High already in the start cycle.

    always_ff @(posedge clk or negedge rstLow) begin
        if (!rstLow) begin
            prev_a <= '0;
            prev_b <= '0;  // Zero divisor is a special case, so no false hit.
        end else if (div_start) begin
            prev_a <= a;
            prev_b <= b;
        end
    end

    // **************************************************
    // Divider
    // **************************************************
    logic  load;
    logic  shift_en;
    logic  step_clear;
    logic  step_en;
    logic  last_step;
    word_t quo;  // Unsigned quotient.
    word_t rem;  // Unsigned remainder.

    div_ctrl_fsm u_fsm (
        .clk          (clk),
        .rstLow       (rstLow),
        .div_start_i  (div_start),
        .last_step_i  (last_step),
        .load_o       (load),
        .shift_en_o   (shift_en),
        .step_clear_o (step_clear),
        .step_en_o    (step_en),
        .div_busy_o   (div_busy)
    );

    div_step_counter u_cnt (
        .clk         (clk),
        .rstLow      (rstLow),
        .clear_i     (step_clear),
        .en_i        (step_en),
        .last_step_o (last_step)
    );

    div_restoring_dp u_dp (
        .clk         (clk),
        .rstLow      (rstLow),
        .load_i      (load),
        .shift_en_i  (shift_en),
        .dividend_i  (a),
        .divisor_i   (b),
        .quotient_o  (quo),
        .remainder_o (rem)
    );

    // **************************************************
    // Result selection
    // **************************************************
    word_t q_out;
    word_t r_out;

    always_comb begin
        if (div0) begin
            q_out = '1;     // Quotient of all ones.
            r_out = rs1_i;  // Remainder is the dividend.
        end else if (div_ovf) begin
            q_out = rs1_i;
            r_out = '0;
        end else begin
            q_out = (sign_a ^ sign_b) ? (~quo + 1'b1) : quo;
            r_out = sign_a ? (~rem + 1'b1) : rem;  // Remainder follows the dividend.
        end
    end

    always_comb begin
        case (funct3_i)
            OP_MUL:                    c_o = prod_s[MSB:0];
            OP_MULH, OP_MULHSU:        c_o = prod_s[2*MSB+1:MSB+1];
            OP_MULHU:                  c_o = prod_u[2*MSB+1:MSB+1];
            OP_DIV, OP_DIVU:           c_o = q_out;
            default:                   c_o = r_out;  // REM and REMU.
        endcase
    end

    // No divider activity survives a reset.
    a_busy_after_reset: assert property (
        @(posedge clk) !$past(rstLow) && rstLow |-> !busy_o
    );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass message.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f --top-module muldiv_tb \
    || { echo "Verilator build did not complete"; exit 1; }

sim_out="$(./obj_dir/Vmuldiv_tb)"
echo "$sim_out"

echo "$sim_out" | grep -qx "Test passed" && exit 0 || exit 1

/* tests/muldiv_tests.svh */
// Directed tests of the multiply/divide unit, included inside the testbench top.
// Each task drives the DUT, checks c_o and busy_o and prints one line.
`ifndef MULDIV_TESTS_SVH
`define MULDIV_TESTS_SVH

// Puts an op on the inputs with start high, returns at the falling edge.
task automatic apply_op(input muldiv_op_e op, input word_t x, input word_t y);
    @(posedge clk);
    funct3 <= op;
    rs1    <= x;
    rs2    <= y;
    start  <= 1'b1;
    @(negedge clk);  // Outputs settled.
endtask

task automatic drop_start();
    @(posedge clk);
    start <= 1'b0;
    @(negedge clk);
endtask

task automatic wait_not_busy();
    int n;
    n = 0;
    while (busy && n < BUSY_LIMIT) begin
        @(negedge clk);
        n++;
    end
    if (busy) begin
        errors++;
        $display("busy_o still high %0d cycles after a start, division never ended", n);
    end
endtask

// Result without the divider: busy stays low, c_o valid at once.
task automatic check_immediate(input muldiv_op_e op, input word_t x, input word_t y);
    apply_op(op, x, y);
    check_value("busy_o", word_t'(busy), '0);
    check_value("c_o", c, div_reference(op, x, y));
    @(negedge clk);
    check_value("busy_o", word_t'(busy), '0);  // No late start.
endtask

task automatic report_test(input string name, input int errors_before);
    tests_run++;
    $display("%-14s finished, %0d errors", name, errors - errors_before);
endtask

task automatic reset_leaves_idle();
    int err0;
    err0 = errors;
    repeat (8) begin
        @(negedge clk);
        check_value("busy_o", word_t'(busy), '0);
    end
    report_test("reset", err0);
endtask

task automatic multiply_ops();
    word_t      xs[$];
    word_t      ys[$];
    muldiv_op_e ops[4];
    int         err0;
    err0 = errors;
    xs   = '{32'h0, 32'h1, 32'hFFFF_FFFF, 32'h8000_0000, 32'h7FFF_FFFF};  // Corners.
    ys   = '{32'hFFFF_FFFF, 32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000, 32'h7FFF_FFFF};
    ops  = '{OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU};
    repeat (8) begin
        xs.push_back(random_bits(32));
        ys.push_back(random_bits(32));
    end
    foreach (ops[k]) begin
        foreach (xs[i]) begin
            apply_op(ops[k], xs[i], ys[i]);
            check_value("c_o", c, mul_reference(ops[k], xs[i], ys[i]));
            check_value("busy_o", word_t'(busy), '0);
        end
    end
    drop_start();
    report_test("multiply", err0);
endtask

task automatic divide_ops();
    muldiv_op_e ops[4];
    word_t      x;
    word_t      y;
    int         err0;
    err0 = errors;
    ops  = '{OP_DIV, OP_DIVU, OP_REM, OP_REMU};
    foreach (ops[k]) begin
        repeat (8) begin
            x = random_bits(32);
            y = random_bits(32) >> random_bits(5);  // Spread of divisor sizes.
            if (y == '0) y = 32'd7;
            if (x == 32'h8000_0000 && y == '1) y = 32'd3;  // Keep clear of overflow.
            apply_op(ops[k], x, y);
            wait_not_busy();
            check_value("c_o", c, div_reference(ops[k], x, y));
            drop_start();
        end
    end
    report_test("divide", err0);
endtask

task automatic special_cases();
    muldiv_op_e ops[4];
    word_t      x;
    int         err0;
    err0 = errors;
    ops  = '{OP_DIV, OP_DIVU, OP_REM, OP_REMU};
    x    = random_bits(32);
    foreach (ops[k]) begin
        check_immediate(ops[k], x, '0);  // Division by zero.
    end
    check_immediate(OP_DIV, 32'h8000_0000, 32'hFFFF_FFFF);
    check_immediate(OP_REM, 32'h8000_0000, 32'hFFFF_FFFF);
    drop_start();
    report_test("special", err0);
endtask

task automatic result_reuse();
    word_t x;
    word_t y;
    int    err0;
    err0 = errors;
    x    = random_bits(32);
    y    = random_bits(16) | 32'h1;
    apply_op(OP_DIV, x, y);
    check_value("busy_o", word_t'(busy), 32'h1);  // Divider really starts.
    wait_not_busy();
    check_value("c_o", c, div_reference(OP_DIV, x, y));
    check_immediate(OP_REM, x, y);  // Remainder already held.
    drop_start();
    x = random_bits(32);
    y = random_bits(20) | 32'h1;
    apply_op(OP_DIVU, x, y);
    check_value("busy_o", word_t'(busy), 32'h1);
    wait_not_busy();
    check_value("c_o", c, div_reference(OP_DIVU, x, y));
    check_immediate(OP_REMU, x, y);
    drop_start();
    report_test("reuse", err0);
endtask

`endif

/* tests/muldiv_tb.sv */
// Directed testbench of the RV32M multiply/divide unit.
// Runs the tests of muldiv_tests.svh against the DUT and prints a verdict.
`include "muldiv_settings.svh"

module muldiv_tb
    import muldiv_pkg::*;
();

    localparam int BUSY_LIMIT = 40;                        // Bound on one division.
    localparam int DIV_CYCLES = `MULDIV_DIV_STEPS + 2;     // Busy time of one division.
    localparam int MAX_CYCLES = 60 * DIV_CYCLES * 2;       // About 60 divisions, doubled.

    logic       clk;
    logic       rstLow;
    word_t      rs1;
    word_t      rs2;
    muldiv_op_e funct3;
    logic       start;
    word_t      c;
    logic       busy;

    int          errors;      // Failed checks so far.
    int          checks;
    int          tests_run;
    int          cycle_cnt;   // Cycles since time zero.
    logic [31:0] lfsr_state;  // Operand generator.

    muldiv_unit DUT (
        .rs1_i    (rs1),
        .rs2_i    (rs2),
        .funct3_i (funct3),
        .start_i  (start),
        .clk      (clk),
        .rstLow   (rstLow),
        .c_o      (c),
        .busy_o   (busy)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // Period 20.
    end

    // **************************************************
    // Operand source and reference models
    // **************************************************
    // Fibonacci LFSR, taps 32, 22, 2 and 1.
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    // One LFSR step per bit taken.
    function automatic word_t random_bits(input int n);
        word_t w;
        w = '0;
        for (int i = 0; i < n; i++) begin
            w = {w[30:0], lfsr_step()};
        end
        return w;
    endfunction

    // Product by the signedness that each op gives its operands.
    function automatic word_t mul_reference(input muldiv_op_e op, input word_t x, input word_t y);
        longint          sx;
        longint          sy;
        longint unsigned ux;
        longint unsigned uy;
        longint unsigned p;
        sx = longint'($signed(x));
        sy = longint'($signed(y));
        ux = {32'b0, x};
        uy = {32'b0, y};
        case (op)
            OP_MUL, OP_MULH: p = sx * sy;
            OP_MULHSU:       p = sx * longint'(uy);  // Signed times unsigned.
            default:         p = ux * uy;
        endcase
        return (op == OP_MUL) ? p[31:0] : p[63:32];
    endfunction

    // RV32M division rules, including the zero divisor and overflow results.
    function automatic word_t div_reference(input muldiv_op_e op, input word_t x, input word_t y);
        logic is_signed;
        logic want_rem;
        int   sx;
        int   sy;
        is_signed = (op == OP_DIV) || (op == OP_REM);
        want_rem  = (op == OP_REM) || (op == OP_REMU);
        sx        = $signed(x);
        sy        = $signed(y);
        if (y == '0) return want_rem ? x : '1;
        if (is_signed && x == 32'h8000_0000 && y == '1) return want_rem ? '0 : x;
        if (is_signed) return want_rem ? word_t'(sx % sy) : word_t'(sx / sy);  // Toward zero.
        return want_rem ? (x % y) : (x / y);
    endfunction

    task automatic check_value(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    `include "muldiv_tests.svh"

    // **************************************************
    // Sequence and verdict
    // **************************************************
    initial begin
        errors     = 0;
        checks     = 0;
        tests_run  = 0;
        lfsr_state = 32'h1c8e_8011;
        rstLow     = 1'b0;
        start      = 1'b0;
        rs1        = '0;
        rs2        = '0;
        funct3     = OP_MUL;
        repeat (16) @(posedge clk);
        rstLow <= 1'b1;
        reset_leaves_idle();
        multiply_ops();
        divide_ops();
        special_cases();
        result_reuse();
        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Stops a run that never reaches the verdict.
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < MAX_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Run stopped after %0d cycles, the tests did not complete.", MAX_CYCLES);
        $display("Test failed");
        $finish;
    end

endmodule
